/* verilog.f */
source/routing_pkg.sv
source/mem_port_if.sv
source/neighbor_mem.sv
source/route_ctrl.sv
source/learn_costs.sv
source/find_best.sv
source/lfsr_rng.sv
source/winner_policy.sv
source/route_top.sv
bench/route_tb.sv

/* run.sh */
#!/bin/sh
# build and run the routing core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module route_tb -f verilog.f -o route_tb_sim

./obj_dir/route_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

/* bench/route_tb.sv */
module route_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] stim_seed = 32'h0395_dbc7;
	// x^32 + x^22 + x^2 + x + 1, right-shifting galois form
	localparam logic [31:0] stim_taps = 32'h8020_0003;
	// worst decision: full find scan, longest modulo, full rescan, plus slack
	localparam int op_cycles = 3 * 64 + 256 + 3 * 64 + 32;
	localparam int op_count = 80;
	localparam int cycle_limit = op_count * op_cycles;

	logic clock, nrst;
	logic pkt_valid, decide, epsilon_load;
	logic [15:0] pkt_source, pkt_cluster, pkt_battery, pkt_value;
	logic [15:0] my_cluster, epsilon_in, epsilon_step;
	logic busy, decision_valid, explored;
	logic [15:0] next_hop, epsilon_now;
	logic [6:0] neighbor_count;

	// reference copy of the neighbor table
	logic [15:0] m_id [0:63];
	logic [15:0] m_cl [0:63];
	logic [15:0] m_bat [0:63];
	logic [15:0] m_q [0:63];
	int m_count = 0;
	// reference epsilon, zero out of reset
	int m_eps = 0;

	logic [31:0] stim_lfsr = stim_seed;
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int decisions = 0;
	int dv_seen = 0;
	logic explored_seen = 1'b0;

	route_top u_dut (
		.clock(clock),
		.nrst(nrst),
		.pkt_valid(pkt_valid),
		.pkt_source(pkt_source),
		.pkt_cluster(pkt_cluster),
		.pkt_battery(pkt_battery),
		.pkt_value(pkt_value),
		.decide(decide),
		.my_cluster(my_cluster),
		.epsilon_load(epsilon_load),
		.epsilon_in(epsilon_in),
		.epsilon_step(epsilon_step),
		.busy(busy),
		.decision_valid(decision_valid),
		.next_hop(next_hop),
		.explored(explored),
		.epsilon_now(epsilon_now),
		.neighbor_count(neighbor_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run exceeded %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// every decision_valid pulse, wanted or not
	always @(negedge clock) begin
		if (nrst && decision_valid) begin
			dv_seen++;
		end
	end

	// a decision only ends inside a busy window
	assert property (@(negedge clock) disable iff (!nrst) decision_valid |-> busy)
	else begin
		$display("failure: decision_valid seen while busy was low");
		other_errors++;
	end

	// one bit per step
	function automatic logic take_bit();
		logic b;
		b = stim_lfsr[0];
		stim_lfsr = stim_lfsr >> 1;
		if (b) begin
			stim_lfsr = stim_lfsr ^ stim_taps;
		end
		return b;
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], take_bit()};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("failure: %s", what);
			other_errors++;
		end
	endtask

	// hit moves q halfway toward the packet value, miss appends
	function automatic void learn_model(input logic [15:0] src, input logic [15:0] cl,
			input logic [15:0] bat, input logic [15:0] val);
		int hit;
		int old_q;
		int diff;
		hit = -1;
		for (int i = 0; i < m_count; i++) begin
			if (m_id[i] == src) hit = i;
		end
		if (hit >= 0) begin
			old_q = int'($signed(m_q[hit]));
			diff = int'($signed(val)) - old_q;
			m_cl[hit] = cl;
			m_bat[hit] = bat;
			m_q[hit] = 16'(old_q + (diff >>> 1));
		end else if (m_count < 64) begin
			m_id[m_count] = src;
			m_cl[m_count] = cl;
			m_bat[m_count] = bat;
			m_q[m_count] = val;
			m_count++;
		end
	endfunction

	function automatic logic eligible(input int i);
		return m_cl[i] == my_cluster && m_bat[i] >= routing_pkg::min_battery;
	endfunction

	// highest signed q, lowest index on ties
	function automatic int best_entry();
		int best;
		best = -1;
		for (int i = 0; i < m_count; i++) begin
			if (eligible(i) && (best < 0 || $signed(m_q[i]) > $signed(m_q[best]))) best = i;
		end
		return best;
	endfunction

	function automatic logic in_eligible_set(input logic [15:0] hop);
		for (int i = 0; i < m_count; i++) begin
			if (eligible(i) && m_id[i] == hop) return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic pause();
		repeat (take_bits(2)) @(posedge clock);
	endtask

	task automatic load_epsilon(input logic [15:0] value, input logic [15:0] step);
		@(posedge clock);
		epsilon_in <= value;
		epsilon_step <= step;
		epsilon_load <= 1'b1;
		@(posedge clock);
		epsilon_load <= 1'b0;
		@(negedge clock);
		m_eps = int'(value);
		check_value("epsilon load", value, epsilon_now);
	endtask

	// poke adds strobes that land while the learn phase is busy
	task automatic send_packet(input logic [15:0] src, input logic [15:0] cl,
			input logic [15:0] bat, input logic [15:0] val, input logic poke);
		@(posedge clock);
		pkt_source <= src;
		pkt_cluster <= cl;
		pkt_battery <= bat;
		pkt_value <= val;
		pkt_valid <= 1'b1;
		@(posedge clock);
		pkt_valid <= 1'b0;
		@(negedge clock);
		check_true(busy, "busy did not rise after pkt_valid");
		if (poke) begin
			repeat (2) @(posedge clock);
			pkt_source <= 16'h0e00;
			pkt_valid <= 1'b1;
			decide <= 1'b1;
			@(posedge clock);
			pkt_valid <= 1'b0;
			decide <= 1'b0;
			@(negedge clock);
		end
		while (busy) @(negedge clock);
		learn_model(src, cl, bat, val);
		check_value("learn neighbor_count", 16'(m_count), 16'(neighbor_count));
		pause();
	endtask

	task automatic run_decision(input logic explore_mode, input logic poke);
		logic [15:0] hop_expected;
		int best;
		@(posedge clock);
		decide <= 1'b1;
		@(posedge clock);
		decide <= 1'b0;
		decisions++;
		@(negedge clock);
		check_true(busy, "busy did not rise after decide");
		// find phase still running here, all three strobes must be dropped
		if (poke) begin
			@(posedge clock);
			pkt_source <= 16'h0d00;
			pkt_valid <= 1'b1;
			decide <= 1'b1;
			epsilon_in <= 16'h0011;
			epsilon_load <= 1'b1;
			@(posedge clock);
			pkt_valid <= 1'b0;
			decide <= 1'b0;
			epsilon_load <= 1'b0;
			@(negedge clock);
		end
		while (!decision_valid) @(negedge clock);
		// saturating decay of the model epsilon
		m_eps = m_eps - int'(epsilon_step);
		if (m_eps < 0) begin
			m_eps = 0;
		end
		check_value("epsilon decay", 16'(m_eps), epsilon_now);
		if (explore_mode) begin
			check_true(in_eligible_set(next_hop), "explore decision left the eligible set");
			if (explored) explored_seen = 1'b1;
		end else begin
			best = best_entry();
			hop_expected = (best < 0) ? routing_pkg::no_hop : m_id[best];
			check_value("exploit next_hop", hop_expected, next_hop);
			check_value("exploit explored", 16'h0000, 16'(explored));
		end
		@(negedge clock);
		check_true(!busy, "busy still high the cycle after decision_valid");
		check_true(!decision_valid, "decision_valid lasted more than one cycle");
		pause();
	endtask

	initial begin
		logic [15:0] src, cl, bat, val;
		nrst = 1'b0;
		pkt_valid = 1'b0;
		decide = 1'b0;
		epsilon_load = 1'b0;
		pkt_source = '0;
		pkt_cluster = '0;
		pkt_battery = '0;
		pkt_value = '0;
		my_cluster = 16'd3;
		epsilon_in = '0;
		epsilon_step = '0;
		repeat (4) @(posedge clock);
		nrst <= 1'b1;
		@(negedge clock);

		// state right out of reset
		check_value("reset busy", 16'h0000, 16'(busy));
		check_value("reset decision_valid", 16'h0000, 16'(decision_valid));
		check_value("reset explored", 16'h0000, 16'(explored));
		check_value("reset neighbor_count", 16'h0000, 16'(neighbor_count));
		check_value("reset epsilon_now", 16'h0000, epsilon_now);

		// pure exploit from here
		load_epsilon(16'd0, 16'd1);
		send_packet(16'h0200, 16'd3, 16'h00ff, 16'd100, 1'b0);
		// q of 40 sits between the old and the moved q of 0200
		send_packet(16'h0201, 16'd3, 16'h00ff, 16'd40, 1'b0);
		// repeated sender, count holds and q moves halfway
		send_packet(16'h0200, 16'd3, 16'h00ff, 16'hffce, 1'b1);
		run_decision(1'b0, 1'b0);

		// random senders from a small pool so repeats happen
		repeat (12) begin
			src = 16'h0100 | take_bits(4);
			cl = take_bit() ? 16'd3 : 16'd5;
			bat = take_bits(8);
			val = take_bits(16);
			send_packet(src, cl, bat, val, take_bit());
		end

		// decisions interleaved with updates to known and new senders
		repeat (8) begin
			run_decision(1'b0, take_bit());
			src = 16'h0100 | take_bits(4);
			cl = take_bit() ? 16'd3 : 16'd5;
			bat = take_bits(8);
			val = take_bits(16);
			send_packet(src, cl, bat, val, 1'b0);
		end

		// nobody lives in cluster 9
		@(posedge clock);
		my_cluster <= 16'd9;
		run_decision(1'b0, 1'b1);
		@(posedge clock);
		my_cluster <= 16'd3;

		// a few sure eligible neighbors before exploring
		for (int i = 0; i < 4; i++) begin
			send_packet(16'h0300 + 16'(i), 16'd3, 16'h0080, take_bits(16), 1'b0);
		end
		load_epsilon(16'd255, 16'd4);
		repeat (16) run_decision(1'b1, take_bit());

		check_true(explored_seen, "explored never went high with epsilon at 255");
		check_value("decision_valid pulses", 16'(decisions), 16'(dv_seen));

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* source/route_top.sv */
module route_top (
	input logic clock,
	input logic nrst,
	input logic pkt_valid,
	input logic [routing_pkg::word_width-1:0] pkt_source,
	input logic [routing_pkg::word_width-1:0] pkt_cluster,
	input logic [routing_pkg::word_width-1:0] pkt_battery,
	input logic [routing_pkg::word_width-1:0] pkt_value,
	input logic decide,
	input logic [routing_pkg::word_width-1:0] my_cluster,
	input logic epsilon_load,
	input logic [routing_pkg::word_width-1:0] epsilon_in,
	input logic [routing_pkg::word_width-1:0] epsilon_step,
	output logic busy,
	output logic decision_valid,
	output logic [routing_pkg::word_width-1:0] next_hop,
	output logic explored,
	output logic [routing_pkg::word_width-1:0] epsilon_now,
	output logic [routing_pkg::count_width-1:0] neighbor_count
);

	logic learn_start, find_start, choose_start;
	logic learn_done, find_done;
	logic [routing_pkg::addr_width-3:0] best_index;
	logic best_valid;
	logic [routing_pkg::count_width-1:0] eligible_count;
	logic rng_step;
	logic [routing_pkg::word_width-1:0] rng_value;

	// one bus to the table, one per stage
	mem_port_if mem_bus ();
	mem_port_if learn_bus ();
	mem_port_if find_bus ();
	mem_port_if choose_bus ();

	neighbor_mem u_mem (
		.clock(clock),
		.mem(mem_bus)
	);

	route_ctrl u_ctrl (
		.clock(clock),
		.nrst(nrst),
		.pkt_valid(pkt_valid),
		.decide(decide),
		.learn_done(learn_done),
		.find_done(find_done),
		.choose_done(decision_valid),
		.busy(busy),
		.learn_start(learn_start),
		.find_start(find_start),
		.choose_start(choose_start),
		.mem_out(mem_bus),
		.learn_mem(learn_bus),
		.find_mem(find_bus),
		.choose_mem(choose_bus)
	);

	learn_costs u_learn (
		.clock(clock),
		.nrst(nrst),
		.start(learn_start),
		.pkt_source(pkt_source),
		.pkt_cluster(pkt_cluster),
		.pkt_battery(pkt_battery),
		.pkt_value(pkt_value),
		.done(learn_done),
		.neighbor_count(neighbor_count),
		.mem(learn_bus)
	);

	find_best u_find (
		.clock(clock),
		.nrst(nrst),
		.start(find_start),
		.my_cluster(my_cluster),
		.neighbor_count(neighbor_count),
		.done(find_done),
		.best_index(best_index),
		.best_valid(best_valid),
		.eligible_count(eligible_count),
		.mem(find_bus)
	);

	lfsr_rng u_rng (
		.clock(clock),
		.nrst(nrst),
		.rng_step(rng_step),
		.rng_value(rng_value)
	);

	// epsilon only loads between operations
	winner_policy u_policy (
		.clock(clock),
		.nrst(nrst),
		.start(choose_start),
		.epsilon_load(epsilon_load && !busy),
		.epsilon_in(epsilon_in),
		.epsilon_step(epsilon_step),
		.my_cluster(my_cluster),
		.neighbor_count(neighbor_count),
		.best_index(best_index),
		.best_valid(best_valid),
		.eligible_count(eligible_count),
		.done(decision_valid),
		.next_hop(next_hop),
		.explored(explored),
		.epsilon_now(epsilon_now),
		.rng_step(rng_step),
		.rng_value(rng_value),
		.mem(choose_bus)
	);

endmodule

/* source/winner_policy.sv */
module winner_policy (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic epsilon_load,
	input logic [routing_pkg::word_width-1:0] epsilon_in,
	input logic [routing_pkg::word_width-1:0] epsilon_step,
	input logic [routing_pkg::word_width-1:0] my_cluster,
	input logic [routing_pkg::count_width-1:0] neighbor_count,
	input logic [routing_pkg::addr_width-3:0] best_index,
	input logic best_valid,
	input logic [routing_pkg::count_width-1:0] eligible_count,
	output logic done,
	output logic [routing_pkg::word_width-1:0] next_hop,
	output logic explored,
	output logic [routing_pkg::word_width-1:0] epsilon_now,
	output logic rng_step,
	input logic [routing_pkg::word_width-1:0] rng_value,
	mem_port_if.master mem
);

	typedef enum logic [3:0] {
		s_idle,
		s_step,
		s_roll,
		s_mod,
		s_rd_cl,
		s_rd_bat,
		s_chk,
		s_read_id,
		s_take
	} state_t;

	state_t state;
	logic [7:0] rank, seen;
	logic [routing_pkg::addr_width-3:0] idx, target;
	logic in_cluster;
	logic [routing_pkg::word_width-1:0] eps_next;
	logic [routing_pkg::word_width-1:0] roll;

	// saturating decay
	assign eps_next = (epsilon_now > epsilon_step) ? epsilon_now - epsilon_step : '0;
	// low byte is the explore roll
	assign roll = {{(routing_pkg::word_width-8){1'b0}}, rng_value[7:0]};
	assign rng_step = (state == s_step);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			done <= 1'b0;
			explored <= 1'b0;
			epsilon_now <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (epsilon_load) begin
						epsilon_now <= epsilon_in;
					end
					if (start) begin
						explored <= 1'b0;
						if (!best_valid) begin
							next_hop <= routing_pkg::no_hop;
							epsilon_now <= eps_next;
							done <= 1'b1;
						end else begin
							state <= s_step;
						end
					end
				end
				// lfsr advances at the end of s_step
				s_step: state <= s_roll;
				s_roll: begin
					if (roll < epsilon_now && eligible_count[routing_pkg::count_width-1:1] != '0) begin
						explored <= 1'b1;
						rank <= rng_value[15:8];
						state <= s_mod;
					end else begin
						target <= best_index;
						state <= s_read_id;
					end
				end
				s_mod: begin
					// rank modulo eligible count by subtraction
					if (rank >= {1'b0, eligible_count}) begin
						rank <= rank - {1'b0, eligible_count};
					end else begin
						idx <= '0;
						seen <= '0;
						state <= s_rd_cl;
					end
				end
				s_rd_cl: state <= s_rd_bat;
				s_rd_bat: begin
					in_cluster <= (mem.rdata == my_cluster);
					state <= s_chk;
				end
				s_chk: begin
					if (in_cluster && mem.rdata >= routing_pkg::min_battery && seen == rank) begin
						target <= idx;
						state <= s_read_id;
					end else if ({1'b0, idx} + 1'b1 >= neighbor_count) begin
						// table ran out, fall back to the best entry
						target <= best_index;
						state <= s_read_id;
					end else begin
						if (in_cluster && mem.rdata >= routing_pkg::min_battery) begin
							seen <= seen + 1'b1;
						end
						idx <= idx + 1'b1;
						state <= s_rd_cl;
					end
				end
				s_read_id: state <= s_take;
				s_take: begin
					next_hop <= mem.rdata;
					epsilon_now <= eps_next;
					done <= 1'b1;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		mem.addr = routing_pkg::field_addr(idx, routing_pkg::field_cluster);
		mem.wr_en = 1'b0;
		mem.wdata = '0;
		case (state)
			s_rd_bat: mem.addr = routing_pkg::field_addr(idx, routing_pkg::field_battery);
			s_read_id: mem.addr = routing_pkg::field_addr(target, routing_pkg::field_id);
			default: ;
		endcase
	end

endmodule

/* source/lfsr_rng.sv */
module lfsr_rng (
	input logic clock,
	input logic nrst,
	input logic rng_step,
	output logic [routing_pkg::word_width-1:0] rng_value
);

	// galois form, taps folded in when a one shifts out
	always_ff @(posedge clock) begin
		if (!nrst) begin
			rng_value <= routing_pkg::lfsr_seed;
		end else if (rng_step) begin
			if (rng_value[0]) begin
				rng_value <= (rng_value >> 1) ^ routing_pkg::lfsr_taps;
			end else begin
				rng_value <= rng_value >> 1;
			end
		end
	end

endmodule

/* source/find_best.sv */
module find_best (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [routing_pkg::word_width-1:0] my_cluster,
	input logic [routing_pkg::count_width-1:0] neighbor_count,
	output logic done,
	output logic [routing_pkg::addr_width-3:0] best_index,
	output logic best_valid,
	output logic [routing_pkg::count_width-1:0] eligible_count,
	mem_port_if.master mem
);

	logic scanning;
	logic issuing;
	// address side of the read pipeline
	logic [routing_pkg::addr_width-3:0] idx;
	routing_pkg::field_t fld;
	// data side, one cycle behind
	logic lag_ok;
	logic [routing_pkg::addr_width-3:0] lag_idx;
	routing_pkg::field_t lag_fld;
	logic in_cluster, battery_ok;
	logic [routing_pkg::word_width-1:0] best_q;
	logic [routing_pkg::count_width-1:0] last;

	assign last = neighbor_count - 1'b1;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			scanning <= 1'b0;
			issuing <= 1'b0;
			lag_ok <= 1'b0;
			done <= 1'b0;
			best_valid <= 1'b0;
			eligible_count <= '0;
		end else begin
			done <= 1'b0;
			if (!scanning) begin
				if (start) begin
					idx <= '0;
					fld <= routing_pkg::field_cluster;
					lag_ok <= 1'b0;
					best_valid <= 1'b0;
					eligible_count <= '0;
					// nothing to scan, report empty right away
					if (neighbor_count == '0) begin
						done <= 1'b1;
					end else begin
						scanning <= 1'b1;
						issuing <= 1'b1;
					end
				end
			end else begin
				lag_idx <= idx;
				lag_fld <= fld;
				lag_ok <= issuing;
				// three reads per entry, id word skipped
				if (issuing) begin
					if (fld == routing_pkg::field_q) begin
						fld <= routing_pkg::field_cluster;
						idx <= idx + 1'b1;
						if ({1'b0, idx} == last) begin
							issuing <= 1'b0;
						end
					end else begin
						fld <= routing_pkg::field_t'(fld + 2'd1);
					end
				end
				if (lag_ok) begin
					case (lag_fld)
						routing_pkg::field_cluster: in_cluster <= (mem.rdata == my_cluster);
						routing_pkg::field_battery: battery_ok <= (mem.rdata >= routing_pkg::min_battery);
						routing_pkg::field_q: begin
							// strict compare keeps the lowest index on ties
							if (in_cluster && battery_ok) begin
								eligible_count <= eligible_count + 1'b1;
								if (!best_valid || $signed(mem.rdata) > $signed(best_q)) begin
									best_q <= mem.rdata;
									best_index <= lag_idx;
									best_valid <= 1'b1;
								end
							end
							if ({1'b0, lag_idx} == last) begin
								done <= 1'b1;
								scanning <= 1'b0;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// read only
	assign mem.addr = routing_pkg::field_addr(idx, fld);
	assign mem.wr_en = 1'b0;
	assign mem.wdata = '0;

endmodule

/* source/learn_costs.sv */
module learn_costs (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [routing_pkg::word_width-1:0] pkt_source,
	input logic [routing_pkg::word_width-1:0] pkt_cluster,
	input logic [routing_pkg::word_width-1:0] pkt_battery,
	input logic [routing_pkg::word_width-1:0] pkt_value,
	output logic done,
	output logic [routing_pkg::count_width-1:0] neighbor_count,
	mem_port_if.master mem
);

	localparam int msb = routing_pkg::word_width - 1;

	typedef enum logic [2:0] {
		s_idle,
		s_scan_addr,
		s_scan_cmp,
		s_miss,
		s_read_q,
		s_calc,
		s_write
	} state_t;

	state_t state;
	logic [routing_pkg::addr_width-3:0] idx;
	routing_pkg::field_t wr_field;
	logic append;
	// packet fields held for the whole update
	logic [msb:0] src, cluster, battery, value;
	logic [msb:0] new_q;
	// old q plus half the signed step toward the packet value
	logic signed [msb+1:0] old_q, diff, half, moved_q;

	assign old_q = {mem.rdata[msb], mem.rdata};
	assign diff = {value[msb], value} - old_q;
	assign half = diff >>> 1;
	assign moved_q = old_q + half;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			done <= 1'b0;
			append <= 1'b0;
			neighbor_count <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						src <= pkt_source;
						cluster <= pkt_cluster;
						battery <= pkt_battery;
						value <= pkt_value;
						idx <= '0;
						// empty table goes straight to append
						state <= (neighbor_count == '0) ? s_miss : s_scan_addr;
					end
				end
				// id address on the port this cycle
				s_scan_addr: state <= s_scan_cmp;
				s_scan_cmp: begin
					if (mem.rdata == src) begin
						state <= s_read_q;
					end else if ({1'b0, idx} + 1'b1 == neighbor_count) begin
						state <= s_miss;
					end else begin
						idx <= idx + 1'b1;
						state <= s_scan_addr;
					end
				end
				s_miss: begin
					// full table drops the packet
					if (neighbor_count == routing_pkg::max_neighbors[routing_pkg::count_width-1:0]) begin
						done <= 1'b1;
						state <= s_idle;
					end else begin
						idx <= neighbor_count[routing_pkg::count_width-2:0];
						new_q <= value;
						wr_field <= routing_pkg::field_id;
						append <= 1'b1;
						state <= s_write;
					end
				end
				s_read_q: state <= s_calc;
				s_calc: begin
					new_q <= moved_q[msb:0];
					wr_field <= routing_pkg::field_cluster;
					append <= 1'b0;
					state <= s_write;
				end
				s_write: begin
					// q is always the last word written
					if (wr_field == routing_pkg::field_q) begin
						done <= 1'b1;
						if (append) begin
							neighbor_count <= neighbor_count + 1'b1;
						end
						state <= s_idle;
					end else begin
						wr_field <= routing_pkg::field_t'(wr_field + 2'd1);
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		mem.addr = routing_pkg::field_addr(idx, routing_pkg::field_id);
		mem.wr_en = 1'b0;
		mem.wdata = new_q;
		case (state)
			s_read_q: mem.addr = routing_pkg::field_addr(idx, routing_pkg::field_q);
			s_write: begin
				mem.addr = routing_pkg::field_addr(idx, wr_field);
				mem.wr_en = 1'b1;
				case (wr_field)
					routing_pkg::field_id: mem.wdata = src;
					routing_pkg::field_cluster: mem.wdata = cluster;
					routing_pkg::field_battery: mem.wdata = battery;
					default: mem.wdata = new_q;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* source/route_ctrl.sv */
module route_ctrl (
	input logic clock,
	input logic nrst,
	input logic pkt_valid,
	input logic decide,
	input logic learn_done,
	input logic find_done,
	input logic choose_done,
	output logic busy,
	output logic learn_start,
	output logic find_start,
	output logic choose_start,
	mem_port_if.master mem_out,
	mem_port_if.memory learn_mem,
	mem_port_if.memory find_mem,
	mem_port_if.memory choose_mem
);

	routing_pkg::phase_t phase;

	// phase sequencer, strobes only seen in idle
	always_ff @(posedge clock) begin
		if (!nrst) begin
			phase <= routing_pkg::phase_idle;
			learn_start <= 1'b0;
			find_start <= 1'b0;
			choose_start <= 1'b0;
		end else begin
			learn_start <= 1'b0;
			find_start <= 1'b0;
			choose_start <= 1'b0;
			case (phase)
				routing_pkg::phase_idle: begin
					// packet wins over a decision in the same cycle
					if (pkt_valid) begin
						phase <= routing_pkg::phase_learn;
						learn_start <= 1'b1;
					end else if (decide) begin
						phase <= routing_pkg::phase_find;
						find_start <= 1'b1;
					end
				end
				routing_pkg::phase_learn: begin
					if (learn_done) begin
						phase <= routing_pkg::phase_idle;
					end
				end
				routing_pkg::phase_find: begin
					// chain straight into the policy stage
					if (find_done) begin
						phase <= routing_pkg::phase_choose;
						choose_start <= 1'b1;
					end
				end
				routing_pkg::phase_choose: begin
					if (choose_done) begin
						phase <= routing_pkg::phase_idle;
					end
				end
				default: phase <= routing_pkg::phase_idle;
			endcase
		end
	end

	assign busy = (phase != routing_pkg::phase_idle);

	// port owner follows phase, writes blocked when nobody owns it
	always_comb begin
		mem_out.addr = learn_mem.addr;
		mem_out.wdata = learn_mem.wdata;
		mem_out.wr_en = 1'b0;
		case (phase)
			routing_pkg::phase_learn: begin
				mem_out.wr_en = learn_mem.wr_en;
			end
			routing_pkg::phase_find: begin
				mem_out.addr = find_mem.addr;
				mem_out.wdata = find_mem.wdata;
				mem_out.wr_en = find_mem.wr_en;
			end
			routing_pkg::phase_choose: begin
				mem_out.addr = choose_mem.addr;
				mem_out.wdata = choose_mem.wdata;
				mem_out.wr_en = choose_mem.wr_en;
			end
			default: ;
		endcase
	end

	// read data fans out to every stage
	assign learn_mem.rdata = mem_out.rdata;
	assign find_mem.rdata = mem_out.rdata;
	assign choose_mem.rdata = mem_out.rdata;

endmodule

/* source/neighbor_mem.sv */
module neighbor_mem (
	input logic clock,
	mem_port_if.memory mem
);

	// four words per neighbor, 64 neighbors
	logic [routing_pkg::word_width-1:0] words [0:(1 << routing_pkg::addr_width)-1];

	// write first, then registered read of the same address
	always_ff @(posedge clock) begin
		if (mem.wr_en) begin
			words[mem.addr] <= mem.wdata;
		end
		// read returns old contents on a write cycle
		mem.rdata <= words[mem.addr];
	end

endmodule

/* source/mem_port_if.sv */
interface mem_port_if;

	logic [routing_pkg::addr_width-1:0] addr;
	logic wr_en;
	logic [routing_pkg::word_width-1:0] wdata;
	// valid the cycle after addr
	logic [routing_pkg::word_width-1:0] rdata;

	modport master (
		output addr,
		output wr_en,
		output wdata,
		input rdata
	);

	modport memory (
		input addr,
		input wr_en,
		input wdata,
		output rdata
	);

endinterface

/* source/routing_pkg.sv */
package routing_pkg;

	// data and table geometry
	localparam int word_width = 16;
	localparam int max_neighbors = 64;
	localparam int addr_width = 8;
	localparam int count_width = 7;

	// eligibility threshold and empty decision marker
	localparam logic [word_width-1:0] min_battery = 16'h0040;
	localparam logic [word_width-1:0] no_hop = 16'hffff;

	// right-shifting galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [word_width-1:0] lfsr_seed = 16'hace1;
	localparam logic [word_width-1:0] lfsr_taps = 16'hb400;

	// word offset of each field inside one four-word entry
	typedef enum logic [1:0] {
		field_id,
		field_cluster,
		field_battery,
		field_q
	} field_t;

	// controller phases
	typedef enum logic [1:0] {
		phase_idle,
		phase_learn,
		phase_find,
		phase_choose
	} phase_t;

	// word address of one field of one entry
	function automatic logic [addr_width-1:0] field_addr(
		input logic [addr_width-3:0] index,
		input field_t field
	);
		return {index, field};
	endfunction

endpackage
